// File: include/alu_tile_defines.svh
`ifndef ALU_TILE_DEFINES_SVH
`define ALU_TILE_DEFINES_SVH

// Execution resources
`define ALU_LANES 3
`define ROB_DEPTH 8

// Host bus
`define WB_DW 32

// Instruction word layout
`define OPC_MSB 31
`define OPC_LSB 28
`define OPA_MSB 27
`define OPA_LSB 14
`define OPB_MSB 13
`define OPB_LSB 0

// Multiply pipe depth, must be 2 or more
`define MUL_LAT 3

`endif

// File: verilog/alu_tile_pkg.sv
`include "alu_tile_defines.svh"

package alu_tile_pkg;

  localparam int ROB_ID_W = $clog2(`ROB_DEPTH);
  localparam int OPND_W   = `OPA_MSB - `OPA_LSB + 1;

  // ----------------------------------------------------------
  // Scalar types
  // ----------------------------------------------------------
  // Codes 7..15 are illegal
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SHL = 4'd5,
    OP_MUL = 4'd6
  } opcode_e;

  typedef logic [OPND_W-1:0]     operand_t;
  typedef logic [ROB_ID_W-1:0]   rob_id_t;
  typedef logic [31:0]           result_t;
  typedef logic [`ALU_LANES-1:0] lane_vec_t;

  // ----------------------------------------------------------
  // Inter-module payloads
  // ----------------------------------------------------------
  // Dispatcher to lane
  typedef struct packed {
    rob_id_t  rob_id;
    opcode_e  opcode;
    operand_t opa;
    operand_t opb;
  } issue_t;

  // Lane to ROB
  typedef struct packed {
    rob_id_t rob_id;
    result_t result;
    logic    illegal;
  } done_t;

  // ROB to commit stream
  typedef struct packed {
    result_t result;
    logic    illegal;
  } cmt_t;

endpackage

// File: verilog/alu_dispatch.sv
`include "alu_tile_defines.svh"

module alu_dispatch (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_wb_cyc,
  input  logic                    i_wb_stb,
  input  logic                    i_wb_we,
  input  logic [`WB_DW-1:0]       i_wb_dat,
  input  alu_tile_pkg::lane_vec_t i_lane_busy,
  input  logic                    i_credit_ret,
  output logic                    o_wb_ack,
  output logic [`WB_DW-1:0]       o_wb_dat,
  output alu_tile_pkg::lane_vec_t o_issue_valid,
  output alu_tile_pkg::issue_t    o_issue
);

  import alu_tile_pkg::*;

  localparam int CRED_W = $clog2(`ROB_DEPTH + 1);

  logic [CRED_W-1:0] r_credit;
  rob_id_t           r_next_id;
  logic [`WB_DW-1:0] r_cmt_cnt;
  logic              r_ack;
  lane_vec_t         r_issue_valid;
  issue_t            r_issue;

  logic      w_req;
  logic      w_wr_take;
  logic      w_rd_take;
  lane_vec_t w_free;
  lane_vec_t w_sel;
  issue_t    w_issue;

  // ----------------------------------------------------------
  // Request qualification
  // ----------------------------------------------------------
  // Nothing new is taken in the ack cycle
  assign w_req  = i_wb_cyc && i_wb_stb && !r_ack;
  assign w_free = ~i_lane_busy;

  // Lowest set bit of the free mask
  assign w_sel = w_free & (~w_free + 1'b1);

  assign w_wr_take = w_req && i_wb_we && (r_credit != '0) && (|w_free);
  assign w_rd_take = w_req && !i_wb_we;

  // Field split of the instruction word
  always_comb begin
    w_issue.rob_id = r_next_id;
    w_issue.opcode = opcode_e'(i_wb_dat[`OPC_MSB:`OPC_LSB]);
    w_issue.opa    = i_wb_dat[`OPA_MSB:`OPA_LSB];
    w_issue.opb    = i_wb_dat[`OPB_MSB:`OPB_LSB];
  end

  // ----------------------------------------------------------
  // Bus handshake and issue
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_ack         <= 1'b0;
      r_issue_valid <= '0;
      r_next_id     <= '0;
    end else begin
      r_ack         <= w_wr_take || w_rd_take;
      r_issue_valid <= w_wr_take ? w_sel : '0;
      if (w_wr_take) begin
        r_next_id <= r_next_id + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_wr_take) begin
      r_issue <= w_issue;
    end
  end

  // ----------------------------------------------------------
  // Credit and commit accounting
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_credit  <= CRED_W'(`ROB_DEPTH);
      r_cmt_cnt <= '0;
    end else begin
      r_credit <= r_credit - CRED_W'(w_wr_take) + CRED_W'(i_credit_ret);
      // One return per retired instruction
      if (i_credit_ret) begin
        r_cmt_cnt <= r_cmt_cnt + 1'b1;
      end
    end
  end

  assign o_wb_ack      = r_ack;
  assign o_wb_dat      = r_cmt_cnt;
  assign o_issue_valid = r_issue_valid;
  assign o_issue       = r_issue;

endmodule

// File: verilog/alu_lane.sv
`include "alu_tile_defines.svh"

module alu_lane (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_issue_valid,
  input  alu_tile_pkg::issue_t i_issue,
  output logic                 o_busy,
  output logic                 o_done_valid,
  output alu_tile_pkg::done_t  o_done
);

  import alu_tile_pkg::*;

  localparam int CNT_W = $clog2(`MUL_LAT + 1);

  result_t w_opa;
  result_t w_opb;
  result_t w_res;
  logic    w_illegal;
  logic    w_is_mul;
  logic    w_mul_last;

  logic             r_mul_pend;
  logic [CNT_W-1:0] r_mul_cnt;
  done_t            r_mul_hold;
  logic             r_done_valid;
  done_t            r_done;

  // Zero extension of both operands
  assign w_opa    = result_t'(i_issue.opa);
  assign w_opb    = result_t'(i_issue.opb);
  assign w_is_mul = (i_issue.opcode == OP_MUL);

  always_comb begin
    w_res     = '0;
    w_illegal = 1'b0;
    case (i_issue.opcode)
      OP_ADD:  w_res = w_opa + w_opb;
      OP_SUB:  w_res = w_opa - w_opb;
      OP_AND:  w_res = w_opa & w_opb;
      OP_OR:   w_res = w_opa | w_opb;
      OP_XOR:  w_res = w_opa ^ w_opb;
      OP_SHL:  w_res = w_opa << w_opb[4:0];
      // 14x14 product fits in 28 bits
      OP_MUL:  w_res = w_opa * w_opb;
      default: w_illegal = 1'b1;
    endcase
  end

  // ----------------------------------------------------------
  // Multiply countdown
  // ----------------------------------------------------------
  assign w_mul_last = r_mul_pend && (r_mul_cnt == CNT_W'(1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_mul_pend   <= 1'b0;
      r_mul_cnt    <= '0;
      r_done_valid <= 1'b0;
    end else begin
      r_done_valid <= (i_issue_valid && !w_is_mul) || w_mul_last;
      if (i_issue_valid && w_is_mul) begin
        r_mul_pend <= 1'b1;
        r_mul_cnt  <= CNT_W'(`MUL_LAT - 1);
      end else if (w_mul_last) begin
        r_mul_pend <= 1'b0;
      end else if (r_mul_pend) begin
        r_mul_cnt <= r_mul_cnt - 1'b1;
      end
    end
  end

  // Product waits in the hold register until the last stage
  always_ff @(posedge i_clk) begin
    if (i_issue_valid && w_is_mul) begin
      r_mul_hold.rob_id  <= i_issue.rob_id;
      r_mul_hold.result  <= w_res;
      r_mul_hold.illegal <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue_valid && !w_is_mul) begin
      r_done.rob_id  <= i_issue.rob_id;
      r_done.result  <= w_res;
      r_done.illegal <= w_illegal;
    end else if (w_mul_last) begin
      r_done <= r_mul_hold;
    end
  end

  // Busy through the done cycle
  assign o_busy       = r_mul_pend || r_done_valid;
  assign o_done_valid = r_done_valid;
  assign o_done       = r_done;

endmodule

// File: verilog/alu_rob.sv
`include "alu_tile_defines.svh"

module alu_rob (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [`ALU_LANES-1:0]  i_done_valid,
  input  alu_tile_pkg::done_t    i_done [`ALU_LANES],
  input  logic                   i_cmt_ready,
  output logic                   o_cmt_valid,
  output alu_tile_pkg::cmt_t     o_cmt,
  output logic                   o_credit_ret
);

  import alu_tile_pkg::*;

  cmt_t                  r_entry [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] r_done;
  rob_id_t               r_head;
  logic                  r_credit_ret;

  logic                  w_cmt_fire;
  logic [`ROB_DEPTH-1:0] w_set;
  logic [`ROB_DEPTH-1:0] w_clr;

  // ----------------------------------------------------------
  // Head view
  // ----------------------------------------------------------
  assign o_cmt_valid = r_done[r_head];
  assign o_cmt       = r_entry[r_head];
  assign w_cmt_fire  = o_cmt_valid && i_cmt_ready;

  // ----------------------------------------------------------
  // Done report capture
  // ----------------------------------------------------------
  // Lanes always carry distinct ids, so writes never collide
  always_ff @(posedge i_clk) begin
    for (int l = 0; l < `ALU_LANES; l++) begin
      if (i_done_valid[l]) begin
        r_entry[i_done[l].rob_id].result  <= i_done[l].result;
        r_entry[i_done[l].rob_id].illegal <= i_done[l].illegal;
      end
    end
  end

  always_comb begin
    w_set = '0;
    w_clr = '0;
    for (int l = 0; l < `ALU_LANES; l++) begin
      if (i_done_valid[l]) begin
        w_set[i_done[l].rob_id] = 1'b1;
      end
    end
    if (w_cmt_fire) begin
      w_clr[r_head] = 1'b1;
    end
  end

  // Set and clear never hit the same entry in one cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_done <= '0;
    end else begin
      r_done <= (r_done & ~w_clr) | w_set;
    end
  end

  // ----------------------------------------------------------
  // In-order retirement
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_head       <= '0;
      r_credit_ret <= 1'b0;
    end else begin
      r_credit_ret <= w_cmt_fire;
      if (w_cmt_fire) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  assign o_credit_ret = r_credit_ret;

endmodule

// File: verilog/alu_tile_top.sv
`include "alu_tile_defines.svh"

module alu_tile_top (
  input  logic               i_clk,
  input  logic               i_rst,

  // Wishbone classic slave
  input  logic               i_wb_cyc,
  input  logic               i_wb_stb,
  input  logic               i_wb_we,
  input  logic [`WB_DW-1:0]  i_wb_dat,
  output logic               o_wb_ack,
  output logic [`WB_DW-1:0]  o_wb_dat,

  // Commit stream
  output logic               o_cmt_valid,
  output alu_tile_pkg::cmt_t o_cmt,
  input  logic               i_cmt_ready
);

  import alu_tile_pkg::*;

  // ----------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------
  lane_vec_t w_issue_valid;
  issue_t    w_issue;
  lane_vec_t w_lane_busy;
  lane_vec_t w_done_valid;
  done_t     w_done [`ALU_LANES];
  logic      w_credit_ret;

  alu_dispatch u_dispatch (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_wb_cyc      (i_wb_cyc),
    .i_wb_stb      (i_wb_stb),
    .i_wb_we       (i_wb_we),
    .i_wb_dat      (i_wb_dat),
    .i_lane_busy   (w_lane_busy),
    .i_credit_ret  (w_credit_ret),
    .o_wb_ack      (o_wb_ack),
    .o_wb_dat      (o_wb_dat),
    .o_issue_valid (w_issue_valid),
    .o_issue       (w_issue)
  );

  // Shared issue bus, per-lane valid
  for (genvar i = 0; i < `ALU_LANES; i++) begin : lane_loop
    alu_lane u_lane (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_issue_valid (w_issue_valid[i]),
      .i_issue       (w_issue),
      .o_busy        (w_lane_busy[i]),
      .o_done_valid  (w_done_valid[i]),
      .o_done        (w_done[i])
    );
  end

  alu_rob u_rob (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_done_valid (w_done_valid),
    .i_done       (w_done),
    .i_cmt_ready  (i_cmt_ready),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt        (o_cmt),
    .o_credit_ret (w_credit_ret)
  );

endmodule

// File: dv/alu_tile_props.sv
module alu_tile_props (
  input logic                    i_clk,
  input logic                    i_rst,
  input logic                    i_wb_cyc,
  input logic                    i_wb_stb,
  input logic                    i_wb_ack,
  input logic                    i_cmt_valid,
  input alu_tile_pkg::cmt_t      i_cmt,
  input logic                    i_cmt_ready,
  input alu_tile_pkg::lane_vec_t i_lane_busy,
  input alu_tile_pkg::lane_vec_t i_done_valid,
  input logic                    i_credit_ret
);

  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------------------------------------
  // Wishbone slave side
  // ------------------------------------------------------------
  ack_needs_request: assert property (@(posedge i_clk) disable iff (i_rst)
    i_wb_ack |-> i_wb_cyc && i_wb_stb)
    else $error("Wishbone ack raised without cyc and stb");

  ack_single_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
    i_wb_ack |=> !i_wb_ack)
    else $error("Wishbone ack held for two cycles");

  // ------------------------------------------------------------
  // Commit stream and reset state
  // ------------------------------------------------------------
  // Stalled head must not move or change
  cmt_hold_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    i_cmt_valid && !i_cmt_ready |=> i_cmt_valid && $stable(i_cmt))
    else $error("Commit payload changed while stalled");

  reset_idle: assert property (@(posedge i_clk)
    i_rst |=> !i_wb_ack && !i_cmt_valid && (i_lane_busy == '0)
      && (i_done_valid == '0) && !i_credit_ret)
    else $error("Outputs not idle during reset");

endmodule

bind alu_tile_top alu_tile_props u_props (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_wb_cyc     (i_wb_cyc),
  .i_wb_stb     (i_wb_stb),
  .i_wb_ack     (o_wb_ack),
  .i_cmt_valid  (o_cmt_valid),
  .i_cmt        (o_cmt),
  .i_cmt_ready  (i_cmt_ready),
  .i_lane_busy  (w_lane_busy),
  .i_done_valid (w_done_valid),
  .i_credit_ret (w_credit_ret)
);

// File: dv/alu_tile_tb.sv
`include "alu_tile_defines.svh"

module alu_tile_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import alu_tile_pkg::*;

  localparam int TABLE_LEN    = 24;
  // First entry written with the commit stream held off
  localparam int STALL_START  = 14;
  localparam int STALL_CYCLES = `ROB_DEPTH * (`MUL_LAT + 3);
  localparam int WATCHDOG_CYC = TABLE_LEN * 200;

  typedef struct packed {
    logic [3:0] opc;
    operand_t   opa;
    operand_t   opb;
    result_t    res;
    logic       ill;
  } vec_t;

  // ------------------------------------------------------------
  // Stimulus table: opcode, operand a, operand b, result, illegal
  // ------------------------------------------------------------
  localparam vec_t VECS [TABLE_LEN] = '{
    '{OP_ADD, 14'd5,     14'd7,     32'd12,         1'b0},
    '{OP_ADD, 14'h3FFF,  14'h3FFF,  32'h0000_7FFE,  1'b0},
    '{OP_SUB, 14'd3,     14'd5,     32'hFFFF_FFFE,  1'b0},
    '{OP_AND, 14'h3C3C,  14'h0FF0,  32'h0000_0C30,  1'b0},
    '{OP_OR,  14'h1200,  14'h0034,  32'h0000_1234,  1'b0},
    '{OP_XOR, 14'h3FFF,  14'h1555,  32'h0000_2AAA,  1'b0},
    '{OP_SHL, 14'd1,     14'd35,    32'd8,          1'b0},
    '{OP_SHL, 14'h3FFF,  14'd31,    32'h8000_0000,  1'b0},
    '{OP_SHL, 14'd3,     14'h3FE4,  32'd48,         1'b0},
    // Slow multiply followed by adds, committed in write order
    '{OP_MUL, 14'h3FFF,  14'h3FFF,  32'h0FFF_8001,  1'b0},
    '{OP_ADD, 14'd1,     14'd2,     32'd3,          1'b0},
    '{OP_ADD, 14'd10,    14'd20,    32'd30,         1'b0},
    '{OP_ADD, 14'd100,   14'd200,   32'd300,        1'b0},
    '{4'd7,   14'd5,     14'd9,     32'd0,          1'b1},
    '{OP_XOR, 14'h00FF,  14'h0F0F,  32'h0000_0FF0,  1'b0},
    '{OP_MUL, 14'd123,   14'd45,    32'd5535,       1'b0},
    '{OP_ADD, 14'd0,     14'd0,     32'd0,          1'b0},
    '{OP_SUB, 14'd0,     14'd1,     32'hFFFF_FFFF,  1'b0},
    '{4'd15,  14'h3FFF,  14'h3FFF,  32'd0,          1'b1},
    '{OP_OR,  14'd0,     14'h2000,  32'h0000_2000,  1'b0},
    '{OP_AND, 14'h3FFF,  14'h3FFF,  32'h0000_3FFF,  1'b0},
    '{OP_MUL, 14'd2,     14'd8191,  32'd16382,      1'b0},
    '{OP_SHL, 14'h0ABC,  14'd8,     32'h000A_BC00,  1'b0},
    '{OP_ADD, 14'h3FFF,  14'd1,     32'h0000_4000,  1'b0}
  };

  logic              i_clk;
  logic              i_rst;
  logic              i_wb_cyc;
  logic              i_wb_stb;
  logic              i_wb_we;
  logic [`WB_DW-1:0] i_wb_dat;
  logic              o_wb_ack;
  logic [`WB_DW-1:0] o_wb_dat;
  logic              o_cmt_valid;
  cmt_t              o_cmt;
  logic              i_cmt_ready;

  cmt_t exp_q [$];
  logic ready_random;
  int   seed      = 65;
  int   n_commits = 0;
  int   wr_cnt    = 0;

  alu_tile_top dut (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_dat    (i_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .o_wb_dat    (o_wb_dat),
    .o_cmt_valid (o_cmt_valid),
    .o_cmt       (o_cmt),
    .i_cmt_ready (i_cmt_ready)
  );

  initial begin : clock_gen
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // ------------------------------------------------------------
  // Host side tasks
  // ------------------------------------------------------------
  function automatic logic [`WB_DW-1:0] pack_instr(input vec_t v);
    logic [`WB_DW-1:0] w;
    w = '0;
    w[`OPC_MSB:`OPC_LSB] = v.opc;
    w[`OPA_MSB:`OPA_LSB] = v.opa;
    w[`OPB_MSB:`OPB_LSB] = v.opb;
    return w;
  endfunction

  task automatic wb_cycle(input logic we, input logic [`WB_DW-1:0] wdat,
                          output logic [`WB_DW-1:0] rdat);
    @(negedge i_clk);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_dat = wdat;
    do begin
      @(negedge i_clk);
    end while (!o_wb_ack);
    rdat = o_wb_dat;
    // Request stays up through the ack edge
    @(negedge i_clk);
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
  endtask

  task automatic send_vec(input vec_t v);
    cmt_t              want;
    logic [`WB_DW-1:0] unused;
    want.result  = v.res;
    want.illegal = v.ill;
    exp_q.push_back(want);
    wb_cycle(1'b1, pack_instr(v), unused);
    wr_cnt++;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
    end
    // Credit and commit count follow the last transfer by one cycle
    repeat (2) @(negedge i_clk);
  endtask

  // ------------------------------------------------------------
  // Commit stream: ready driver and checker
  // ------------------------------------------------------------
  initial begin : commit_check
    logic [31:0] rnd;
    cmt_t        want;
    i_cmt_ready = 1'b0;
    forever begin
      @(negedge i_clk);
      rnd = $random(seed);
      i_cmt_ready = ready_random && (rnd[1:0] != 2'b00);
      if (!i_rst && o_cmt_valid && i_cmt_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("Commit at %0t with no write outstanding", $time);
          $display("Simulation failed");
          $fatal(1, "Stopping on first error");
        end
        want = exp_q.pop_front();
        assert (o_cmt == want) else begin
          $display("MISMATCH at %0t: commit %0d result %h illegal %b, expected %h illegal %b",
                   $time, n_commits, o_cmt.result, o_cmt.illegal, want.result, want.illegal);
          $display("Simulation failed");
          $fatal(1, "Stopping on first error");
        end
        n_commits++;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge i_clk);
    $display("Timeout after %0d cycles with %0d of %0d commits seen",
             WATCHDOG_CYC, n_commits, TABLE_LEN);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin : main_seq
    logic [`WB_DW-1:0] rd_data;
    i_rst        = 1'b1;
    i_wb_cyc     = 1'b0;
    i_wb_stb     = 1'b0;
    i_wb_we      = 1'b0;
    i_wb_dat     = '0;
    ready_random = 1'b1;
    repeat (8) @(negedge i_clk);
    i_rst = 1'b0;

    for (int i = 0; i < STALL_START; i++) begin
      send_vec(VECS[i]);
    end
    wait_drain();

    // Commit stream held off until the ROB is full and writes stall
    @(posedge i_clk);
    ready_random = 1'b0;
    fork
      begin
        for (int i = STALL_START; i < TABLE_LEN; i++) begin
          send_vec(VECS[i]);
        end
      end
      begin
        repeat (STALL_CYCLES) @(negedge i_clk);
        assert (wr_cnt == STALL_START + `ROB_DEPTH) else begin
          $display("MISMATCH at %0t: %0d writes acked while stalled, expected %0d",
                   $time, wr_cnt, STALL_START + `ROB_DEPTH);
          $display("Simulation failed");
          $fatal(1, "Stopping on first error");
        end
        // Oldest stalled entry waits at the head
        assert (o_cmt_valid && o_cmt == exp_q[0]) else begin
          $display("MISMATCH at %0t: stalled head valid %b result %h illegal %b, %s",
                   $time, o_cmt_valid, o_cmt.result, o_cmt.illegal, "expected valid");
          $display("MISMATCH at %0t: stalled head expected result %h illegal %b",
                   $time, exp_q[0].result, exp_q[0].illegal);
          $display("Simulation failed");
          $fatal(1, "Stopping on first error");
        end
        @(posedge i_clk);
        ready_random = 1'b1;
      end
    join
    wait_drain();

    wb_cycle(1'b0, '0, rd_data);
    assert (rd_data == 32'(TABLE_LEN)) else begin
      $display("MISMATCH at %0t: commit count read %0d, expected %0d",
               $time, rd_data, TABLE_LEN);
      $display("Simulation failed");
      $fatal(1, "Stopping on first error");
    end

    if (n_commits == TABLE_LEN && !o_cmt_valid) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Run ended with %0d of %0d commits and commit valid %b",
               n_commits, TABLE_LEN, o_cmt_valid);
      $display("Simulation failed");
      $fatal(1, "Incomplete run");
    end
  end

endmodule

// File: tb.f
+incdir+include
verilog/alu_tile_pkg.sv
verilog/alu_dispatch.sv
verilog/alu_lane.sv
verilog/alu_rob.sv
verilog/alu_tile_top.sv
dv/alu_tile_props.sv
dv/alu_tile_tb.sv

// File: Makefile
SIM        = verilator
TOP        = alu_tile_tb
FILELIST   = tb.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
